// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_icache with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/icache_data_store.sv
`timescale 1ns/1ns

module icache_data_store (
    input  logic                    Clk,
    input  logic                    rst,
    input  logic                    read_enable,
    input  logic                    hit,
    input  logic                    busy,
    input  icache_pkg::fetch_addr_t fetch_addr,
    input  icache_pkg::way_idx_t    hit_way,
    input  icache_pkg::refill_wr_t  refill_wr,
    input  icache_pkg::word_t       critical_word,
    input  logic                    refill_done,
    output icache_pkg::word_t       instruction,
    output logic                    ready
);
    import icache_pkg::*;

    // One whole block per entry
    word_t [BLOCK_WORDS-1:0] data_array [NUM_SETS][NUM_WAYS];

    logic  hit_accept;
    word_t hit_word;

    assign hit_accept = read_enable && hit && !busy;
    assign hit_word   = data_array[fetch_addr.set][hit_way][fetch_addr.offset];

    always_ff @(posedge Clk) begin
        if (refill_wr.valid) begin
            data_array[refill_wr.set][refill_wr.way] <= refill_wr.words;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            ready <= 1'b0;
        end else begin
            ready <= hit_accept || refill_done;
        end
    end

    // Holds the last response between pulses
    always_ff @(posedge Clk) begin
        if (refill_done) begin
            instruction <= critical_word;
        end else if (hit_accept) begin
            instruction <= hit_word;
        end
    end

endmodule

// File: rtl/icache_lookup.sv
`timescale 1ns/1ns

module icache_lookup (
    input  logic                    Clk,
    input  logic                    rst,
    input  icache_pkg::addr_t       read_address,
    input  icache_pkg::refill_wr_t  refill_wr,
    output icache_pkg::fetch_addr_t fetch_addr,
    output logic                    hit,
    output icache_pkg::way_idx_t    hit_way,
    output icache_pkg::way_idx_t    victim_way
);
    import icache_pkg::*;

    tag_t                tag_array   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_array [NUM_SETS];
    way_idx_t            rr_ptr      [NUM_SETS];

    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] way_match;

    // Tag, set and word offset in address order
    assign fetch_addr = read_address[31:WORD_OFFSET_BITS];

    assign set_valid = valid_array[fetch_addr.set];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = set_valid[w] && (tag_array[fetch_addr.set][w] == fetch_addr.tag);
        end
    end

    assign hit = |way_match;

    // At most one way matches, scan order only matters for X-free output
    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way_match[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // Lowest invalid way, else the round-robin pointer
    always_comb begin
        victim_way = rr_ptr[fetch_addr.set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_array[s] <= '0;
                rr_ptr[s]      <= '0;
            end
        end else if (refill_wr.valid) begin
            valid_array[refill_wr.set][refill_wr.way] <= 1'b1;
            // Pointer moves on every fill, invalid way or not
            rr_ptr[refill_wr.set] <= way_idx_t'(rr_ptr[refill_wr.set] + 1'b1);
        end
    end

    always_ff @(posedge Clk) begin
        if (refill_wr.valid) begin
            tag_array[refill_wr.set][refill_wr.way] <= refill_wr.tag;
        end
    end

endmodule

// File: rtl/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int NUM_SETS          = 8;
    localparam int NUM_WAYS          = 4;
    localparam int BLOCK_WORDS       = 4;
    localparam int WORD_OFFSET_BITS  = 2;
    localparam int BLOCK_OFFSET_BITS = $clog2(BLOCK_WORDS);
    localparam int SET_BITS          = $clog2(NUM_SETS);
    localparam int TAG_BITS          = 32 - SET_BITS - BLOCK_OFFSET_BITS - WORD_OFFSET_BITS;

    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [SET_BITS-1:0]          set_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]  way_idx_t;
    typedef logic [BLOCK_OFFSET_BITS-1:0] word_off_t;

    // Extra bit so the count can reach BLOCK_WORDS
    typedef logic [BLOCK_OFFSET_BITS:0]   beat_cnt_t;

    // Fetch address without the byte-in-word bits
    typedef struct packed {
        tag_t      tag;
        set_idx_t  set;
        word_off_t offset;
    } fetch_addr_t;

    // One whole-block write into tag, valid and data arrays
    typedef struct packed {
        logic                     valid;
        set_idx_t                 set;
        way_idx_t                 way;
        tag_t                     tag;
        word_t [BLOCK_WORDS-1:0]  words;
    } refill_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        COLLECT,
        WRITE
    } refill_state_e;

endpackage

// File: rtl/icache_refill.sv
`timescale 1ns/1ns

module icache_refill (
    input  logic                    Clk,
    input  logic                    rst,
    input  logic                    read_enable,
    input  logic                    hit,
    input  icache_pkg::fetch_addr_t fetch_addr,
    input  icache_pkg::way_idx_t    victim_way,
    input  icache_pkg::word_t       mem_data_in,
    input  logic                    mem_data_ready,
    output logic                    busy,
    output icache_pkg::addr_t       mem_read_address,
    output logic                    mem_read_request,
    output icache_pkg::refill_wr_t  refill_wr,
    output icache_pkg::word_t       critical_word,
    output logic                    refill_done
);
    import icache_pkg::*;

    refill_state_e           state;
    fetch_addr_t             miss_addr;
    way_idx_t                miss_way;
    beat_cnt_t               beat_cnt;
    word_t [BLOCK_WORDS-1:0] block_buf;

    logic miss_accept;
    logic collecting;
    logic last_beat;

    assign miss_accept = read_enable && !hit && (state == IDLE);

    // Beats are taken as soon as the request is out
    assign collecting = (state == REQUEST) || (state == COLLECT);
    assign last_beat  = collecting && mem_data_ready
                        && (beat_cnt == beat_cnt_t'(BLOCK_WORDS - 1));

    always_ff @(posedge Clk) begin
        if (rst) begin
            state            <= IDLE;
            busy             <= 1'b0;
            mem_read_request <= 1'b0;
            beat_cnt         <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss_accept) begin
                        state            <= REQUEST;
                        busy             <= 1'b1;
                        mem_read_request <= 1'b1;
                        beat_cnt         <= '0;
                    end
                end
                REQUEST, COLLECT: begin
                    if (mem_data_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state            <= WRITE;
                        mem_read_request <= 1'b0;
                    end else begin
                        state <= COLLECT;
                    end
                end
                WRITE: begin
                    // Arrays and response register update on this edge
                    state <= IDLE;
                    busy  <= 1'b0;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Miss context, held for the whole refill
    always_ff @(posedge Clk) begin
        if (miss_accept) begin
            miss_addr        <= fetch_addr;
            miss_way         <= victim_way;
            mem_read_address <= {fetch_addr.tag, fetch_addr.set,
                                 {(BLOCK_OFFSET_BITS + WORD_OFFSET_BITS){1'b0}}};
        end
    end

    // Controller returns beats in address order
    always_ff @(posedge Clk) begin
        if (collecting && mem_data_ready) begin
            block_buf[beat_cnt[BLOCK_OFFSET_BITS-1:0]] <= mem_data_in;
        end
    end

    assign refill_done = (state == WRITE);

    assign refill_wr.valid = refill_done;
    assign refill_wr.set   = miss_addr.set;
    assign refill_wr.way   = miss_way;
    assign refill_wr.tag   = miss_addr.tag;
    assign refill_wr.words = block_buf;

    assign critical_word = block_buf[miss_addr.offset];

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/1ns

module icache_top (
    input  logic              Clk,
    input  logic              rst,
    input  logic              ReadEnable,
    input  icache_pkg::addr_t ReadAddress,
    output icache_pkg::word_t Instruction,
    output logic              Ready,
    output logic              Busy,
    output icache_pkg::addr_t MemReadAddress,
    output logic              MemReadRequest,
    input  icache_pkg::word_t MemDataIn,
    input  logic              MemDataReady
);
    import icache_pkg::*;

    fetch_addr_t fetch_addr;
    logic        hit;
    way_idx_t    hit_way;
    way_idx_t    victim_way;
    refill_wr_t  refill_wr;
    word_t       critical_word;
    logic        refill_done;

    icache_lookup u_lookup (
        .Clk          (Clk),
        .rst          (rst),
        .read_address (ReadAddress),
        .refill_wr    (refill_wr),
        .fetch_addr   (fetch_addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way)
    );

    icache_refill u_refill (
        .Clk              (Clk),
        .rst              (rst),
        .read_enable      (ReadEnable),
        .hit              (hit),
        .fetch_addr       (fetch_addr),
        .victim_way       (victim_way),
        .mem_data_in      (MemDataIn),
        .mem_data_ready   (MemDataReady),
        .busy             (Busy),
        .mem_read_address (MemReadAddress),
        .mem_read_request (MemReadRequest),
        .refill_wr        (refill_wr),
        .critical_word    (critical_word),
        .refill_done      (refill_done)
    );

    icache_data_store u_data_store (
        .Clk           (Clk),
        .rst           (rst),
        .read_enable   (ReadEnable),
        .hit           (hit),
        .busy          (Busy),
        .fetch_addr    (fetch_addr),
        .hit_way       (hit_way),
        .refill_wr     (refill_wr),
        .critical_word (critical_word),
        .refill_done   (refill_done),
        .instruction   (Instruction),
        .ready         (Ready)
    );

endmodule

// File: tb.f
rtl/icache_pkg.sv
rtl/icache_lookup.sv
rtl/icache_refill.sv
rtl/icache_data_store.sv
rtl/icache_top.sv
tests/mem_model.sv
tests/icache_assert.sv
tests/tb_icache.sv

// File: tests/icache_assert.sv
`timescale 1ns/1ns

module icache_assert (
    input logic              Clk,
    input logic              rst,
    input logic              ready,
    input logic              busy,
    input logic              mem_read_request,
    input icache_pkg::addr_t mem_read_address
);
    import icache_pkg::*;

    ready_single_cycle: assert property (@(posedge Clk) disable iff (rst)
        ready |=> !ready)
        else $error("Ready high in two consecutive cycles");

    request_within_busy: assert property (@(posedge Clk) disable iff (rst)
        mem_read_request |-> busy)
        else $error("MemReadRequest high while Busy is low");

    // Offset bits of the block address must be zero
    request_aligned: assert property (@(posedge Clk) disable iff (rst)
        mem_read_request |->
            mem_read_address[BLOCK_OFFSET_BITS+WORD_OFFSET_BITS-1:0] == '0)
        else $error("MemReadAddress not block aligned");

    ready_request_exclusive: assert property (@(posedge Clk) disable iff (rst)
        !(ready && mem_read_request))
        else $error("Ready and MemReadRequest high together");

endmodule

bind icache_top icache_assert u_assert (
    .Clk              (Clk),
    .rst              (rst),
    .ready            (Ready),
    .busy             (Busy),
    .mem_read_request (MemReadRequest),
    .mem_read_address (MemReadAddress)
);

// File: tests/mem_model.sv
`timescale 1ns/1ns

module mem_model #(
    parameter int unsigned SEED = 0
) (
    input  logic              Clk,
    input  logic              rst,
    input  logic              read_request,
    input  icache_pkg::addr_t read_address,
    output icache_pkg::word_t data,
    output logic              data_ready
);
    import icache_pkg::*;

    // Word at byte address A is A with its upper half inverted
    function automatic word_t mem_word(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    initial begin
        addr_t       base;
        int unsigned gap;
        void'($urandom(SEED));
        data       = '0;
        data_ready = 1'b0;
        forever begin
            @(negedge Clk);
            if (read_request && !rst) begin
                base = read_address;
                // Beats in address order, each after zero to three idle cycles
                for (int b = 0; b < BLOCK_WORDS; b++) begin
                    gap = $urandom_range(3);
                    repeat (gap) @(negedge Clk);
                    data       = mem_word(base + addr_t'(b * 4));
                    data_ready = 1'b1;
                    @(negedge Clk);
                    data_ready = 1'b0;
                end
            end
        end
    end

endmodule

// File: tests/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_REQUESTS  = 39;
    localparam int BLOCK_BYTES   = BLOCK_WORDS * 4;
    // Accept and request, beats with up to three idle cycles each, write, response
    localparam int REFILL_CYCLES = 2 + BLOCK_WORDS * 4 + 2;
    localparam int FETCH_TIMEOUT = REFILL_CYCLES + 10;
    localparam int WATCHDOG_NS   =
        (RESET_CYCLES + 20 + NUM_REQUESTS * FETCH_TIMEOUT) * CLK_PERIOD;

    logic  Clk;
    logic  rst;
    logic  read_enable;
    addr_t read_address;
    word_t instruction;
    logic  ready;
    logic  busy;
    addr_t mem_read_address;
    logic  mem_read_request;
    word_t mem_data_in;
    logic  mem_data_ready;

    int checks;
    int errors;

    icache_top dut0 (
        .Clk            (Clk),
        .rst            (rst),
        .ReadEnable     (read_enable),
        .ReadAddress    (read_address),
        .Instruction    (instruction),
        .Ready          (ready),
        .Busy           (busy),
        .MemReadAddress (mem_read_address),
        .MemReadRequest (mem_read_request),
        .MemDataIn      (mem_data_in),
        .MemDataReady   (mem_data_ready)
    );

    mem_model #(.SEED(32'hbdcad7a1)) mem0 (
        .Clk          (Clk),
        .rst          (rst),
        .read_request (mem_read_request),
        .read_address (mem_read_address),
        .data         (mem_data_in),
        .data_ready   (mem_data_ready)
    );

    initial Clk = 1'b0;
    always #(CLK_PERIOD / 2) Clk = ~Clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the cache stopped responding", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    function automatic word_t expected_word(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int off);
        return addr_t'(tag * NUM_SETS * BLOCK_BYTES + set * BLOCK_BYTES + off * 4);
    endfunction

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("Check failed: %s", what);
        end
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expect_idle_outputs();
        compare_word("Ready", word_t'(ready), 32'h0);
        compare_word("Busy", word_t'(busy), 32'h0);
        compare_word("MemReadRequest", word_t'(mem_read_request), 32'h0);
    endtask

    // One fetch pulse, then wait for Ready while watching the memory port
    task automatic fetch(input addr_t addr, output word_t data, output logic saw_req,
                         output addr_t req_addr, output int latency);
        logic done;
        done     = 1'b0;
        saw_req  = 1'b0;
        req_addr = '0;
        data     = '0;
        @(negedge Clk);
        read_enable  = 1'b1;
        read_address = addr;
        @(negedge Clk);
        read_enable = 1'b0;
        latency     = 1;
        while (!done && latency <= FETCH_TIMEOUT) begin
            if (mem_read_request && !saw_req) begin
                saw_req  = 1'b1;
                req_addr = mem_read_address;
            end
            if (ready) begin
                done = 1'b1;
                data = instruction;
            end else begin
                @(negedge Clk);
                latency++;
            end
        end
        require(done, $sformatf("no Ready within %0d cycles for fetch at %h",
                                FETCH_TIMEOUT, addr));
    endtask

    task automatic fetch_and_check(input addr_t addr, input logic expect_miss);
        word_t data;
        logic  saw_req;
        addr_t req_addr;
        int    latency;
        fetch(addr, data, saw_req, req_addr, latency);
        compare_word($sformatf("Instruction at %h", addr), data, expected_word(addr));
        if (expect_miss) begin
            require(saw_req, $sformatf("no MemReadRequest for miss at %h", addr));
            compare_word("MemReadAddress", req_addr, addr & ~addr_t'(BLOCK_BYTES - 1));
        end else begin
            require(!saw_req, $sformatf("MemReadRequest raised for hit at %h", addr));
            compare_word("Ready latency", word_t'(latency), 32'h1);
        end
    endtask

    task automatic reset_sequence();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge Clk);
            expect_idle_outputs();
            if (i == RESET_CYCLES - 1) begin
                rst = 1'b0;
            end
        end
        @(negedge Clk);
        expect_idle_outputs();
    endtask

    task automatic cold_miss();
        fetch_and_check(make_addr('h100, 1, 2), 1'b1);
    endtask

    task automatic block_hits();
        for (int off = 0; off < BLOCK_WORDS; off++) begin
            fetch_and_check(make_addr('h100, 1, off), 1'b0);
        end
    endtask

    task automatic replacement();
        for (int t = 0; t <= NUM_WAYS; t++) begin
            fetch_and_check(make_addr('h200 + t, 5, t % BLOCK_WORDS), 1'b1);
        end
        // Pointer wrapped to way 0, so the fifth block replaced the first
        fetch_and_check(make_addr('h201, 5, 0), 1'b0);
        fetch_and_check(make_addr('h200, 5, 3), 1'b1);
    endtask

    task automatic stalled_misses();
        for (int i = 0; i < 24; i++) begin
            fetch_and_check(make_addr('h300 + i, i % NUM_SETS, i % BLOCK_WORDS), 1'b1);
        end
    endtask

    task automatic request_while_busy();
        addr_t a_addr;
        addr_t b_addr;
        addr_t h_addr;
        word_t data;
        logic  prev_req;
        int    cycles;
        int    ready_count;
        int    req_rises;
        int    after_ready;
        a_addr      = make_addr('h400, 2, 1);
        b_addr      = make_addr('h401, 3, 3);
        // Still resident from the cold miss
        h_addr      = make_addr('h100, 1, 0);
        data        = '0;
        prev_req    = 1'b0;
        ready_count = 0;
        req_rises   = 0;
        after_ready = 0;
        @(negedge Clk);
        read_enable  = 1'b1;
        read_address = a_addr;
        @(negedge Clk);
        read_enable = 1'b0;
        cycles      = 1;
        while (after_ready < 6 && cycles <= FETCH_TIMEOUT) begin
            if (mem_read_request && !prev_req) begin
                req_rises++;
            end
            prev_req = mem_read_request;
            if (ready_count > 0) begin
                after_ready++;
            end
            if (ready) begin
                ready_count++;
                data = instruction;
            end
            // A missing pulse and then a hitting pulse, both in the middle of the refill
            if (cycles == 2 || cycles == 4) begin
                compare_word("Busy", word_t'(busy), 32'h1);
                read_enable  = 1'b1;
                read_address = (cycles == 2) ? b_addr : h_addr;
            end else begin
                read_enable = 1'b0;
            end
            @(negedge Clk);
            cycles++;
        end
        compare_word("Ready pulse count", word_t'(ready_count), 32'h1);
        compare_word("MemReadRequest rise count", word_t'(req_rises), 32'h1);
        compare_word("Instruction", data, expected_word(a_addr));
        // The ignored pulse must not have filled its block
        fetch_and_check(b_addr, 1'b1);
    endtask

    initial begin
        checks       = 0;
        errors       = 0;
        rst          = 1'b1;
        read_enable  = 1'b0;
        read_address = '0;
        reset_sequence();
        cold_miss();
        block_hits();
        replacement();
        stalled_misses();
        request_while_busy();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
